/* verilog/div_defines.svh */
////////////////////////////////////////////////////////////
// widths, opcode and function codes for the RV32M divider
////////////////////////////////////////////////////////////

`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

////////////////////////////////////////////////////////////
// datapath
////////////////////////////////////////////////////////////

`define DIV_XLEN       32          // operand and result width
`define DIV_CNT_W      5           // log2 of DIV_XLEN

////////////////////////////////////////////////////////////
// instruction encoding
////////////////////////////////////////////////////////////

// register-register major opcode
`define DIV_OPC_OP     7'b0110011
`define DIV_F7_MULDIV  7'b0000001  // M extension funct7

// funct3 of the divide group
`define DIV_F3_DIV     3'b100
`define DIV_F3_DIVU    3'b101
`define DIV_F3_REM     3'b110
`define DIV_F3_REMU    3'b111

`endif

/* verilog/div_pkg.sv */
////////////////////////////////////////////////////////////
// instruction word views, issue and decode types
////////////////////////////////////////////////////////////

`default_nettype none

`include "div_defines.svh"

package div_pkg;

  ////////////////////////////////////////////////////////////
  // instruction word
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rtype_t;

  // same 32 bits, raw or split into R-type fields
  typedef union packed {
    logic [31:0] raw;
    rtype_t      r;
  } insn_u;

  typedef struct packed {
    logic  bubble;  // slot carries no instruction
    insn_u insn;
  } div_insn_t;

  ////////////////////////////////////////////////////////////
  // decode result
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_DIV  = 2'b00,
    OP_DIVU = 2'b01,
    OP_REM  = 2'b10,
    OP_REMU = 2'b11
  } div_op_e;

  typedef struct packed {
    logic                 valid;      // divide-class instruction
    div_op_e              op;
    logic                 early;      // result known without dividing
    logic [`DIV_XLEN-1:0] early_val;
    logic [`DIV_XLEN-1:0] dividend;   // magnitude
    logic [`DIV_XLEN-1:0] divisor;    // magnitude
    logic                 neg_q;      // negate quotient
    logic                 neg_s;      // negate remainder
  } div_setup_t;

endpackage

`default_nettype wire

/* verilog/div_setup.sv */
////////////////////////////////////////////////////////////
// divide instruction decode, early results, operand magnitudes
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "div_defines.svh"

module div_setup (
  input  div_pkg::div_insn_t   id_insn_i,
  input  logic [`DIV_XLEN-1:0] opa_i,
  input  logic [`DIV_XLEN-1:0] opb_i,
  output div_pkg::div_setup_t  setup_o
);

  localparam logic [`DIV_XLEN-1:0] MIN_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};

  div_pkg::rtype_t      rt;
  logic                 valid;
  div_pkg::div_op_e     op;
  logic                 is_signed;
  logic                 div_zero;
  logic                 ovf;
  logic [`DIV_XLEN-1:0] early_val;
  logic                 sign_a;
  logic                 sign_b;

  assign rt = id_insn_i.insn.r;   // R-type view of the word

  ////////////////////////////////////////////////////////////
  // operation decode
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    valid = 1'b0;
    op    = div_pkg::OP_DIV;
    if (rt.opcode == `DIV_OPC_OP && rt.funct7 == `DIV_F7_MULDIV)
    begin
      case (rt.funct3)
        `DIV_F3_DIV:
        begin
          valid = 1'b1;
          op    = div_pkg::OP_DIV;
        end
        `DIV_F3_DIVU:
        begin
          valid = 1'b1;
          op    = div_pkg::OP_DIVU;
        end
        `DIV_F3_REM:
        begin
          valid = 1'b1;
          op    = div_pkg::OP_REM;
        end
        `DIV_F3_REMU:
        begin
          valid = 1'b1;
          op    = div_pkg::OP_REMU;
        end
        default: valid = 1'b0;   // MUL group
      endcase
    end
  end

  assign is_signed = (op == div_pkg::OP_DIV) || (op == div_pkg::OP_REM);
  assign sign_a    = is_signed & opa_i[`DIV_XLEN-1];
  assign sign_b    = is_signed & opb_i[`DIV_XLEN-1];

  // exceptions
  assign div_zero = ~|opb_i;
  assign ovf      = is_signed && (opa_i == MIN_NEG) && (&opb_i);  // -2^31 / -1

  always_comb
  begin
    case (op)
      div_pkg::OP_DIV,
      div_pkg::OP_DIVU: early_val = div_zero ? {`DIV_XLEN{1'b1}} : MIN_NEG;
      default:          early_val = div_zero ? opa_i : '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // decode result
  ////////////////////////////////////////////////////////////

  assign setup_o.valid     = valid;
  assign setup_o.op        = op;
  assign setup_o.early     = div_zero | ovf;
  assign setup_o.early_val = early_val;
  assign setup_o.dividend  = sign_a ? -opa_i : opa_i;
  assign setup_o.divisor   = sign_b ? -opb_i : opb_i;
  assign setup_o.neg_q     = sign_a ^ sign_b;
  assign setup_o.neg_s     = sign_a;

endmodule

`default_nettype wire

/* verilog/div_core.sv */
////////////////////////////////////////////////////////////
// restoring shift-subtract datapath and step counter
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "div_defines.svh"

module div_core (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  load_i,
  input  logic                  step_i,
  input  div_pkg::div_setup_t   setup_i,
  output logic                  last_o,
  output logic [`DIV_XLEN-1:0]  quot_o,
  output logic [`DIV_XLEN-1:0]  rem_o
);

  logic [`DIV_XLEN-1:0]  p_q;        // partial remainder
  logic [`DIV_XLEN-1:0]  a_q;        // dividend, becomes quotient
  logic [`DIV_XLEN-1:0]  b_q;        // divisor
  logic [`DIV_CNT_W-1:0] cnt_q;
  logic [`DIV_XLEN:0]    p_shl;      // remainder shifted, one extra bit
  logic [`DIV_XLEN:0]    p_minus_b;

  assign p_shl     = {p_q, a_q[`DIV_XLEN-1]};
  assign p_minus_b = p_shl - {1'b0, b_q};

  // step counter
  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
      cnt_q <= '0;
    else if (load_i)
      cnt_q <= '1;
    else if (step_i)
      cnt_q <= cnt_q - 1'b1;

  ////////////////////////////////////////////////////////////
  // shift-subtract pair
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (load_i)
    begin
      p_q <= '0;
      a_q <= setup_i.dividend;
      b_q <= setup_i.divisor;
    end
    else if (step_i)
    begin
      if (p_minus_b[`DIV_XLEN])   // negative, restore
      begin
        p_q <= p_shl[`DIV_XLEN-1:0];
        a_q <= {a_q[`DIV_XLEN-2:0], 1'b0};
      end
      else
      begin
        p_q <= p_minus_b[`DIV_XLEN-1:0];
        a_q <= {a_q[`DIV_XLEN-2:0], 1'b1};
      end
    end
  end

  assign last_o = ~|cnt_q;
  assign quot_o = a_q;
  assign rem_o  = p_q;

endmodule

`default_nettype wire

/* verilog/div_ctrl.sv */
////////////////////////////////////////////////////////////
// divider FSM, stall and bubble generation, result register
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "div_defines.svh"

module div_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 ex_stall_i,
  input  logic                 mem_stall_i,
  input  logic                 bubble_i,
  input  div_pkg::div_setup_t  setup_i,
  input  logic                 last_i,
  input  logic [`DIV_XLEN-1:0] quot_i,
  input  logic [`DIV_XLEN-1:0] rem_i,
  output logic                 load_o,
  output logic                 step_o,
  output logic                 div_stall_o,
  output logic                 div_bubble_o,
  output logic [`DIV_XLEN-1:0] div_r_o
);

  typedef enum logic [1:0] {
    ST_CHK = 2'b00,
    ST_DIV = 2'b01,
    ST_RES = 2'b10
  } state_e;

  state_e               state_q;
  logic                 issue;
  logic                 res_done;
  div_pkg::div_op_e     op_q;      // latched at issue
  logic                 neg_q_q;
  logic                 neg_s_q;
  logic [`DIV_XLEN-1:0] res_fix;   // sign corrected result

  assign issue    = (state_q == ST_CHK) && !ex_stall_i && !bubble_i && setup_i.valid;
  assign load_o   = issue && !setup_i.early;
  assign step_o   = (state_q == ST_DIV);
  assign res_done = (state_q == ST_RES) && !mem_stall_i;

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
    if (!rst_ni)
    begin
      state_q      <= ST_CHK;
      div_stall_o  <= 1'b0;
      div_bubble_o <= 1'b1;
    end
    else
    begin
      div_bubble_o <= 1'b1;   // single cycle pulse low
      case (state_q)
        ST_CHK:
          if (issue)
          begin
            if (setup_i.early)
              div_bubble_o <= 1'b0;
            else
            begin
              state_q     <= ST_DIV;
              div_stall_o <= 1'b1;
            end
          end
        ST_DIV: if (last_i) state_q <= ST_RES;   // last step this edge
        ST_RES:
          if (!mem_stall_i)
          begin
            state_q      <= ST_CHK;
            div_stall_o  <= 1'b0;
            div_bubble_o <= 1'b0;
          end
        default: state_q <= ST_CHK;
      endcase
    end

  // quotient or remainder, then sign fix
  always_comb
  begin
    case (op_q)
      div_pkg::OP_DIV:  res_fix = neg_q_q ? -quot_i : quot_i;
      div_pkg::OP_DIVU: res_fix = quot_i;
      div_pkg::OP_REM:  res_fix = neg_s_q ? -rem_i : rem_i;
      default:          res_fix = rem_i;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (load_o)
    begin
      op_q    <= setup_i.op;
      neg_q_q <= setup_i.neg_q;
      neg_s_q <= setup_i.neg_s;
    end
    if (issue && setup_i.early)
      div_r_o <= setup_i.early_val;
    else if (res_done)
      div_r_o <= res_fix;
  end

endmodule

`default_nettype wire

/* verilog/riscv_div.sv */
////////////////////////////////////////////////////////////
// RV32M divider top, decode + datapath + controller
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "div_defines.svh"

module riscv_div (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mem_stall_i,
  input  logic                 ex_stall_i,
  input  div_pkg::div_insn_t   id_insn_i,
  input  logic [`DIV_XLEN-1:0] opa_i,
  input  logic [`DIV_XLEN-1:0] opb_i,
  output logic                 div_stall_o,
  output logic                 div_bubble_o,
  output logic [`DIV_XLEN-1:0] div_r_o
);

  div_pkg::div_setup_t  setup;
  logic                 load;
  logic                 step;
  logic                 last;
  logic [`DIV_XLEN-1:0] quot;
  logic [`DIV_XLEN-1:0] rem;

  div_setup u_setup (
    .id_insn_i (id_insn_i),
    .opa_i     (opa_i),
    .opb_i     (opb_i),
    .setup_o   (setup)
  );

  div_core u_core (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_i    (load),
    .step_i    (step),
    .setup_i   (setup),
    .last_o    (last),
    .quot_o    (quot),
    .rem_o     (rem)
  );

  div_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ex_stall_i   (ex_stall_i),
    .mem_stall_i  (mem_stall_i),
    .bubble_i     (id_insn_i.bubble),   // empty issue slot
    .setup_i      (setup),
    .last_i       (last),
    .quot_i       (quot),
    .rem_i        (rem),
    .load_o       (load),
    .step_o       (step),
    .div_stall_o  (div_stall_o),
    .div_bubble_o (div_bubble_o),
    .div_r_o      (div_r_o)
  );

endmodule

`default_nettype wire

/* bench/tb_clkgen.sv */
////////////////////////////////////////////////////////////
// testbench clock and reset source
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_NS = 20;   // 40 ns period

  initial
  begin
    clk_o = 1'b0;
    forever #HALF_NS clk_o = ~clk_o;
  end

  // low for 4 rising edges, released on a falling edge
  initial
  begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/riscv_div_chk.sv */
////////////////////////////////////////////////////////////
// stall and bubble protocol assertions, bound to riscv_div
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module riscv_div_chk (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                ex_stall_i,
  input logic                insn_bubble_i,
  input div_pkg::div_setup_t setup_i,
  input logic                stall_i,
  input logic                bubble_i
);

  logic start;   // a full division is accepted this cycle

  assign start = !stall_i && !ex_stall_i && !insn_bubble_i && setup_i.valid && !setup_i.early;

  bubble_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !bubble_i |=> bubble_i)
    else $error("result pulse held low for more than one cycle");

  // stall only rises after an accepted division
  stall_needs_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !stall_i && !start |=> !stall_i)
    else $error("stall raised without a division being issued");

  bubble_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i |-> bubble_i)
    else $error("result pulse while the divider is busy");

  stall_ends_with_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(stall_i) |-> !bubble_i)
    else $error("stall released without a result pulse");

endmodule

bind riscv_div riscv_div_chk u_chk (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .ex_stall_i    (ex_stall_i),
  .insn_bubble_i (id_insn_i.bubble),
  .setup_i       (setup),
  .stall_i       (div_stall_o),
  .bubble_i      (div_bubble_o)
);

`default_nettype wire

/* bench/tb_riscv_div.sv */
////////////////////////////////////////////////////////////
// RV32M divider testbench, reference model and compare process
////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "div_defines.svh"

module tb_riscv_div;

  localparam int          N_RAND    = 160;
  localparam int          NUM_TESTS = N_RAND + 16;
  localparam int          MAX_STALL = 8;
  localparam longint      WATCHDOG_NS = (NUM_TESTS + 4) * (`DIV_XLEN + MAX_STALL + 4) * 40;
  localparam logic [31:0] SEED      = 32'h1c2f_d79a;
  localparam logic [`DIV_XLEN-1:0] MIN_NEG = {1'b1, {(`DIV_XLEN-1){1'b0}}};

  logic                 clk;
  logic                 rst_n;
  logic                 mem_stall;
  logic                 ex_stall;
  div_pkg::div_insn_t   id_insn;
  logic [`DIV_XLEN-1:0] opa;
  logic [`DIV_XLEN-1:0] opb;
  logic                 div_stall_o;
  logic                 div_bubble_o;
  logic [`DIV_XLEN-1:0] div_r_o;

  logic [31:0]          lfsr_q;
  int                   err_cnt;
  logic [`DIV_XLEN-1:0] exp_q[$];   // expected results in issue order
  string                tag_q[$];

  tb_clkgen u_clkgen (.clk_o(clk), .rst_no(rst_n));

  riscv_div dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .mem_stall_i  (mem_stall),
    .ex_stall_i   (ex_stall),
    .id_insn_i    (id_insn),
    .opa_i        (opa),
    .opb_i        (opb),
    .div_stall_o  (div_stall_o),
    .div_bubble_o (div_bubble_o),
    .div_r_o      (div_r_o)
  );

  task automatic report_error(input string line);
    err_cnt++;
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  ////////////////////////////////////////////////////////////
  // random source and instruction helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // right-shifting galois step
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic div_pkg::div_insn_t make_insn(input logic [2:0] f3, input logic [6:0] f7,
                                                   input logic [6:0] opc);
    div_pkg::div_insn_t w;
    w.bubble        = 1'b0;
    w.insn.r.funct7 = f7;
    w.insn.r.rs2    = 5'd12;
    w.insn.r.rs1    = 5'd11;
    w.insn.r.funct3 = f3;
    w.insn.r.rd     = 5'd10;
    w.insn.r.opcode = opc;
    return w;
  endfunction

  function automatic div_pkg::div_insn_t idle_insn();
    div_pkg::div_insn_t w;
    w.bubble   = 1'b1;
    w.insn.raw = 32'h0000_0013;   // nop in an empty slot
    return w;
  endfunction

  function automatic logic [2:0] op_f3(input int sel);
    case (sel)
      0:       op_f3 = `DIV_F3_DIV;
      1:       op_f3 = `DIV_F3_DIVU;
      2:       op_f3 = `DIV_F3_REM;
      default: op_f3 = `DIV_F3_REMU;
    endcase
  endfunction

  function automatic string op_name(input logic [2:0] f3);
    case (f3)
      `DIV_F3_DIV:  op_name = "div";
      `DIV_F3_DIVU: op_name = "divu";
      `DIV_F3_REM:  op_name = "rem";
      default:      op_name = "remu";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model by the RISC-V M rules
  ////////////////////////////////////////////////////////////

  function automatic logic early_case(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    logic sgn;
    sgn = (f3 == `DIV_F3_DIV) || (f3 == `DIV_F3_REM);
    early_case = (b == '0) || (sgn && a == MIN_NEG && b == '1);
  endfunction

  function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic        [31:0] r;
    sa = a;
    sb = b;
    case (f3)
      `DIV_F3_DIV:
        if (b == '0)                     r = '1;
        else if (a == MIN_NEG && b == '1) r = MIN_NEG;
        else                             r = sa / sb;   // truncates toward zero
      `DIV_F3_DIVU:
        if (b == '0) r = '1;
        else         r = a / b;
      `DIV_F3_REM:
        if (b == '0)                     r = a;
        else if (a == MIN_NEG && b == '1) r = '0;
        else                             r = sa % sb;   // sign of dividend
      default:
        if (b == '0) r = a;
        else         r = a % b;
    endcase
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  // issue one division and hold mem stall for hold cycles once the result is due
  task automatic run_div(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b,
                         input int hold);
    logic [31:0] v;
    logic        early;
    int          exp_r;   // edge after issue that should carry the result
    int          k;
    bit          done;
    early = early_case(f3, a, b);
    exp_r = early ? 0 : -1;
    done  = 1'b0;
    k     = 0;
    @(negedge clk);
    id_insn   = make_insn(f3, `DIV_F7_MULDIV, `DIV_OPC_OP);
    opa       = a;
    opb       = b;
    ex_stall  = 1'b0;
    mem_stall = 1'b0;
    exp_q.push_back(ref_result(f3, a, b));
    tag_q.push_back($sformatf("%s %h, %h", op_name(f3), a, b));
    while (!done)
    begin
      @(negedge clk);
      k++;
      if (k == 1)
      begin
        id_insn = idle_insn();
        take_bits(32, v);
        opa = v;              // operands must already be captured
        take_bits(32, v);
        opb = v;
      end
      if (div_bubble_o === 1'b0)
      begin
        assert (k - 1 == exp_r)
          else report_error($sformatf("[FAIL] %0t: %s result on edge %0d, expected edge %0d",
                                      $time, op_name(f3), k - 1, exp_r));
        assert (div_stall_o === 1'b0)
          else report_error($sformatf("[FAIL] %0t: stall still high with result", $time));
        mem_stall = 1'b0;
        done      = 1'b1;
      end
      else
      begin
        assert (exp_r < 0 || k - 1 < exp_r)
          else report_error($sformatf("[FAIL] %0t: %s result missing on edge %0d",
                                      $time, op_name(f3), exp_r));
        assert (div_stall_o === !early)
          else report_error($sformatf("[FAIL] %0t: stall is %b while waiting for %s",
                                      $time, div_stall_o, op_name(f3)));
        take_bits(2, v);
        if (early)
          mem_stall = 1'b0;
        else if (k >= `DIV_XLEN + 1)
        begin
          mem_stall = (k < `DIV_XLEN + 1 + hold) ||
                      (k < `DIV_XLEN + 1 + MAX_STALL && v[1:0] == 2'b00);
          if (!mem_stall)
            exp_r = k;
        end
        else
          mem_stall = (v[1:0] == 2'b00);   // ignored while dividing
      end
    end
  endtask

  // present an instruction that must not start anything
  task automatic run_quiet(input div_pkg::div_insn_t w, input logic ex_hold, input string what);
    logic [31:0] v;
    @(negedge clk);
    id_insn  = w;
    ex_stall = ex_hold;
    take_bits(32, v);
    opa = v;
    take_bits(32, v);
    opb = v;
    for (int k = 0; k < `DIV_XLEN + 4; k++)
    begin
      @(negedge clk);
      if (k == 3)
      begin
        id_insn  = idle_insn();
        ex_stall = 1'b0;
      end
      assert (div_bubble_o === 1'b1 && div_stall_o === 1'b0)
        else report_error($sformatf("%s started the divider", what));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare process and watchdog
  ////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin : compare
    logic [`DIV_XLEN-1:0] exp_val;
    string                tag;
    if (rst_n === 1'b1 && div_bubble_o === 1'b0)
    begin
      assert (exp_q.size() != 0)
        else report_error("result pulse seen with no division issued");
      exp_val = exp_q.pop_front();
      tag     = tag_q.pop_front();
      assert (div_r_o === exp_val)
        else report_error($sformatf("[FAIL] %0t: %s gave %h, expected %h",
                                    $time, tag, div_r_o, exp_val));
    end
  end

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    report_error($sformatf("timeout, the run did not finish within %0d ns", WATCHDOG_NS));
  end

  initial
  begin : main
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        v;
    div_pkg::div_insn_t w;
    lfsr_q    = SEED;
    err_cnt   = 0;
    id_insn   = idle_insn();
    opa       = '0;
    opb       = '0;
    ex_stall  = 1'b0;
    mem_stall = 1'b0;

    @(negedge clk);
    assert (div_bubble_o === 1'b1 && div_stall_o === 1'b0)
      else report_error("outputs not idle during reset");
    wait (rst_n === 1'b1);
    for (int i = 0; i < 3; i++)
    begin
      @(negedge clk);
      assert (div_bubble_o === 1'b1 && div_stall_o === 1'b0)
        else report_error("outputs not idle after reset");
    end

    // zero divisor and signed overflow
    for (int i = 0; i < 4; i++)
    begin
      take_bits(32, a);
      run_div(op_f3(i), a, '0, 0);
    end
    run_div(`DIV_F3_DIV, '0, '0, 0);
    for (int i = 0; i < 4; i++)
      run_div(op_f3(i), MIN_NEG, '1, 0);

    // back-pressure in the result state
    run_div(`DIV_F3_DIV, 32'h8765_4321, 32'h0000_0123, MAX_STALL);
    run_div(`DIV_F3_REMU, 32'hfedc_ba98, 32'h0001_0001, 3);

    // nothing may start
    w        = make_insn(`DIV_F3_DIV, `DIV_F7_MULDIV, `DIV_OPC_OP);
    w.bubble = 1'b1;
    run_quiet(w, 1'b0, "bubble-flagged div");
    run_quiet(make_insn(`DIV_F3_DIVU, `DIV_F7_MULDIV, `DIV_OPC_OP), 1'b1, "divu under ex stall");
    run_quiet(make_insn(3'b000, `DIV_F7_MULDIV, `DIV_OPC_OP), 1'b0, "mul");
    run_quiet(make_insn(`DIV_F3_DIV, 7'b0000000, `DIV_OPC_OP), 1'b0, "xor");

    // random operands with some narrowed
    for (int i = 0; i < N_RAND; i++)
    begin
      take_bits(32, a);
      take_bits(32, b);
      take_bits(5, v);
      case (v[2:0])
        3'd0: b = b >> 24;   // small divisor
        3'd1: a = a >> 16;
        3'd4: b = b >> 28;   // sometimes zero
        default: ;
      endcase
      run_div(op_f3(int'(v[4:3])), a, b, 0);
    end

    @(negedge clk);
    if (err_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/div_pkg.sv
verilog/div_setup.sv
verilog/div_core.sv
verilog/div_ctrl.sv
verilog/riscv_div.sv
bench/tb_clkgen.sv
bench/riscv_div_chk.sv
bench/tb_riscv_div.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_riscv_div
FILELIST  := verilog.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: sim clean

# build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
